// File: Bender.yml
package:
  name: mfp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mfp_pkg.sv
      - source/mfp_byte_fifo.sv
      - source/mfp_timer.sv
      - source/mfp_regs.sv
      - source/mfp_irq_ctrl.sv
      - source/mfp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/mfp_tb.sv

// File: include/mfp_macros.svh
`ifndef MFP_MACROS_SVH
`define MFP_MACROS_SVH

// entries per uart fifo, both directions
`define MFP_FIFO_DEPTH 4

// register address width on the cpu bus
`define MFP_ADDR_W 5

// interrupt sources handled by the controller
// split into an A half (15:8) and a B half (7:0)
`define MFP_NUM_IRQ 16

`endif

// File: source/mfp_byte_fifo.sv
`timescale 1ns/1ps

module mfp_byte_fifo #(
	parameter int DEPTH = 4
) (
	input  logic       iack,
	input  logic       reset,
	input  logic       push_i,
	input  logic [7:0] data_i,
	input  logic       pop_i,
	output logic [7:0] data_o,
	output logic       full_o,
	output logic       avail_o
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	// push while full is dropped, pop while empty is ignored
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && avail_o;

	assign full_o  = (count == (AW+1)'(DEPTH));
	assign avail_o = (count != '0);
	// head byte, zero when nothing is stored
	assign data_o  = avail_o ? mem[rd_ptr] : 8'h00;

	always_ff @(posedge iack) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap at DEPTH, which need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: source/mfp_irq_ctrl.sv
`timescale 1ns/1ps
`include "mfp_macros.svh"

module mfp_irq_ctrl (
	input  logic                    iack,
	input  logic                    reset,
	input  logic [`MFP_NUM_IRQ-1:0] src_i,
	input  logic [`MFP_NUM_IRQ-1:0] ier_i,
	input  logic [`MFP_NUM_IRQ-1:0] imr_i,
	input  logic [7:0]              vr_i,
	input  logic [`MFP_NUM_IRQ-1:0] ipr_clear_i,
	input  logic [`MFP_NUM_IRQ-1:0] isr_clear_i,
	input  logic                    int_ack_i,
	output logic [`MFP_NUM_IRQ-1:0] ipr_o,
	output logic [`MFP_NUM_IRQ-1:0] isr_o,
	output logic [7:0]              vector_o,
	output logic                    irq_o
);
	import mfp_pkg::*;

	logic [`MFP_NUM_IRQ-1:0] src_q;
	logic [`MFP_NUM_IRQ-1:0] edge_set;
	logic [`MFP_NUM_IRQ-1:0] masked;
	logic [`MFP_NUM_IRQ-1:0] ack_clr;
	logic [`MFP_NUM_IRQ-1:0] ack_set;
	logic                    ack_q;
	logic                    ack_edge;
	logic                    pend_any;
	logic                    isr_any;
	irq_src_e                pend_num;
	irq_src_e                isr_num;

	// number of the highest set bit, 0 when none is set
	function automatic irq_src_e top_bit(input logic [`MFP_NUM_IRQ-1:0] v);
		irq_src_e n;
		n = IRQ_GPIO0;
		for (int i = 0; i < `MFP_NUM_IRQ; i++) begin
			if (v[i])
				n = irq_src_e'(i);
		end
		return n;
	endfunction

	// rising edge of each source level, only for enabled sources
	assign edge_set = src_i & ~src_q & ier_i;

	assign masked   = ipr_o & imr_i;
	assign pend_any = |masked;
	assign isr_any  = |isr_o;
	assign pend_num = top_bit(masked);
	assign isr_num  = top_bit(isr_o);

	// request only above the level currently in service
	assign irq_o = pend_any && (!isr_any || (pend_num > isr_num));

	assign ack_edge = int_ack_i && !ack_q;

	// winner leaves IPR, enters ISR only with the S bit set
	always_comb begin
		ack_clr = '0;
		if (ack_edge && pend_any)
			ack_clr[pend_num] = 1'b1;
		ack_set = vr_i[3] ? ack_clr : '0;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			src_q    <= '0;
			ack_q    <= 1'b0;
			ipr_o    <= '0;
			isr_o    <= '0;
			vector_o <= '0;
		end else begin
			src_q <= src_i;
			ack_q <= int_ack_i;
			// a new edge in the same cycle beats a clear
			ipr_o <= (ipr_o & ~ipr_clear_i & ~ack_clr) | edge_set;
			isr_o <= (isr_o & ~isr_clear_i) | ack_set;
			// held for the rest of the acknowledge
			if (ack_edge)
				vector_o <= {vr_i[7:4], pend_num};
		end
	end

endmodule

// File: source/mfp_pkg.sv
`include "mfp_macros.svh"

package mfp_pkg;

	// cpu visible register map
	typedef enum logic [`MFP_ADDR_W-1:0] {
		GPIP  = 5'h00, AER   = 5'h01, DDR   = 5'h02,
		IERA  = 5'h03, IERB  = 5'h04, IPRA  = 5'h05, IPRB  = 5'h06,
		ISRA  = 5'h07, ISRB  = 5'h08, IMRA  = 5'h09, IMRB  = 5'h0A,
		VR    = 5'h0B,
		TACR  = 5'h0C, TBCR  = 5'h0D, TCDCR = 5'h0E,
		TADR  = 5'h0F, TBDR  = 5'h10, TCDR  = 5'h11, TDDR  = 5'h12,
		SCR   = 5'h13, UCR   = 5'h14, RSR   = 5'h15, TSR   = 5'h16,
		UDR   = 5'h17
	} mfp_reg_e;

	// timer control field, stop or delay mode with prescaler
	typedef enum logic [2:0] {
		TM_STOP, TM_DIV4, TM_DIV10, TM_DIV16,
		TM_DIV50, TM_DIV64, TM_DIV100, TM_DIV200
	} timer_mode_e;

	// bit position of each source in IER/IPR/ISR/IMR
	// higher number wins arbitration
	typedef enum logic [3:0] {
		IRQ_GPIO0, IRQ_GPIO1, IRQ_GPIO2, IRQ_GPIO3,
		IRQ_TIMER_D, IRQ_TIMER_C, IRQ_GPIO4, IRQ_GPIO5,
		IRQ_TIMER_B, IRQ_TX_ERR, IRQ_TX_EMPTY, IRQ_RX_ERR,
		IRQ_RX_FULL, IRQ_TIMER_A, IRQ_GPIO6, IRQ_GPIO7
	} irq_src_e;

endpackage

// File: source/mfp_regs.sv
`timescale 1ns/1ps
`include "mfp_macros.svh"

module mfp_regs (
	input  logic                     iack,
	input  logic                     reset,
	input  logic                     sel_i,
	input  logic                     ds_n_i,
	input  logic                     rw_i,
	input  mfp_pkg::mfp_reg_e        addr_i,
	input  logic [7:0]               din_i,
	input  logic                     int_ack_i,
	input  logic [7:0]               gpio_i,
	input  logic [`MFP_NUM_IRQ-1:0]  ipr_i,
	input  logic [`MFP_NUM_IRQ-1:0]  isr_i,
	input  logic [7:0]               vector_i,
	input  logic [3:0][7:0]          tmr_dat_i,
	input  logic [7:0]               rx_data_i,
	input  logic                     rx_avail_i,
	input  logic                     tx_full_i,
	output logic [7:0]               dout_o,
	output logic [7:0]               aer_o,
	output logic [`MFP_NUM_IRQ-1:0]  ier_o,
	output logic [`MFP_NUM_IRQ-1:0]  imr_o,
	output logic [7:0]               vr_o,
	output logic [`MFP_NUM_IRQ-1:0]  ipr_clear_o,
	output logic [`MFP_NUM_IRQ-1:0]  isr_clear_o,
	output logic [3:0]               tmr_ctrl_we_o,
	output mfp_pkg::timer_mode_e     tmr_mode_o [4],
	output logic [3:0]               tmr_dat_we_o,
	output logic [7:0]               tmr_dat_o,
	output logic                     tx_push_o,
	output logic                     rx_pop_o
);
	import mfp_pkg::*;

	logic       access;
	logic       access_q;
	logic       first;
	logic       wr;
	logic       rd;
	logic [7:0] gpip;
	logic [7:0] ddr;
	logic [7:0] scr;
	logic [7:1] ucr;
	logic [1:0] rsr_ctrl;
	logic [3:0] tsr_ctrl;

	assign access = sel_i && !ds_n_i;
	// only the first cycle of a held strobe acts
	assign first  = access && !access_q;
	assign wr     = first && !rw_i;
	// read data is shown for the whole access
	assign rd     = access && rw_i;

	always_ff @(posedge iack) begin
		if (reset)
			access_q <= 1'b0;
		else
			access_q <= access;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			gpip     <= '0;
			aer_o    <= '0;
			ddr      <= '0;
			ier_o    <= '0;
			imr_o    <= '0;
			vr_o     <= '0;
			scr      <= '0;
			ucr      <= '0;
			rsr_ctrl <= '0;
			tsr_ctrl <= '0;
			for (int t = 0; t < 4; t++)
				tmr_mode_o[t] <= TM_STOP;
		end else if (wr) begin
			case (addr_i)
				GPIP:  gpip <= din_i;
				AER:   aer_o <= din_i;
				DDR:   ddr <= din_i;
				IERA:  ier_o[15:8] <= din_i;
				IERB:  ier_o[7:0] <= din_i;
				IMRA:  imr_o[15:8] <= din_i;
				IMRB:  imr_o[7:0] <= din_i;
				VR:    vr_o <= din_i;
				TACR:  tmr_mode_o[0] <= timer_mode_e'(din_i[2:0]);
				TBCR:  tmr_mode_o[1] <= timer_mode_e'(din_i[2:0]);
				// timer C in the upper nibble, timer D in the lower
				TCDCR: begin
					tmr_mode_o[2] <= timer_mode_e'(din_i[6:4]);
					tmr_mode_o[3] <= timer_mode_e'(din_i[2:0]);
				end
				// uart control is stored only
				SCR:   scr <= din_i;
				UCR:   ucr <= din_i[7:1];
				RSR:   rsr_ctrl <= din_i[1:0];
				TSR:   tsr_ctrl <= din_i[3:0];
				default: ;
			endcase
		end
	end

	// zero data bits clear IPR/ISR, disabling a source also drops its pending bit
	always_comb begin
		ipr_clear_o = '0;
		isr_clear_o = '0;
		if (wr) begin
			case (addr_i)
				IERA, IPRA: ipr_clear_o[15:8] = ~din_i;
				IERB, IPRB: ipr_clear_o[7:0] = ~din_i;
				ISRA:       isr_clear_o[15:8] = ~din_i;
				ISRB:       isr_clear_o[7:0] = ~din_i;
				default: ;
			endcase
		end
	end

	// timer strobes, index 0..3 is timer A..D
	assign tmr_ctrl_we_o[0] = wr && (addr_i == TACR);
	assign tmr_ctrl_we_o[1] = wr && (addr_i == TBCR);
	assign tmr_ctrl_we_o[2] = wr && (addr_i == TCDCR);
	assign tmr_ctrl_we_o[3] = wr && (addr_i == TCDCR);
	assign tmr_dat_we_o[0]  = wr && (addr_i == TADR);
	assign tmr_dat_we_o[1]  = wr && (addr_i == TBDR);
	assign tmr_dat_we_o[2]  = wr && (addr_i == TCDR);
	assign tmr_dat_we_o[3]  = wr && (addr_i == TDDR);
	assign tmr_dat_o        = din_i;

	// uart data register feeds the out fifo and drains the in fifo
	assign tx_push_o = wr && (addr_i == UDR);
	assign rx_pop_o  = first && rw_i && (addr_i == UDR) && rx_avail_i;

	always_comb begin
		dout_o = 8'h00;
		if (rd) begin
			case (addr_i)
				// pins where DDR is 0, written bits where it is 1
				GPIP:  dout_o = (gpio_i & ~ddr) | (gpip & ddr);
				AER:   dout_o = aer_o;
				DDR:   dout_o = ddr;
				IERA:  dout_o = ier_o[15:8];
				IERB:  dout_o = ier_o[7:0];
				IPRA:  dout_o = ipr_i[15:8];
				IPRB:  dout_o = ipr_i[7:0];
				ISRA:  dout_o = isr_i[15:8];
				ISRB:  dout_o = isr_i[7:0];
				IMRA:  dout_o = imr_o[15:8];
				IMRB:  dout_o = imr_o[7:0];
				VR:    dout_o = vr_o;
				TACR:  dout_o = {5'b0, tmr_mode_o[0]};
				TBCR:  dout_o = {5'b0, tmr_mode_o[1]};
				TCDCR: dout_o = {1'b0, tmr_mode_o[2], 1'b0, tmr_mode_o[3]};
				TADR:  dout_o = tmr_dat_i[0];
				TBDR:  dout_o = tmr_dat_i[1];
				TCDR:  dout_o = tmr_dat_i[2];
				TDDR:  dout_o = tmr_dat_i[3];
				SCR:   dout_o = scr;
				UCR:   dout_o = {ucr, 1'b0};
				// bit 7 is buffer full, i.e. in fifo holds data
				RSR:   dout_o = {rx_avail_i, 5'b0, rsr_ctrl};
				// bit 7 is buffer empty, reported while the out fifo has room
				TSR:   dout_o = {~tx_full_i, 3'b0, tsr_ctrl};
				UDR:   dout_o = rx_data_i;
				default: dout_o = 8'h00;
			endcase
		end else if (int_ack_i) begin
			dout_o = vector_i;
		end
	end

endmodule

// File: source/mfp_timer.sv
`timescale 1ns/1ps

module mfp_timer (
	input  logic                iack,
	input  logic                reset,
	input  logic                ctrl_we_i,
	input  mfp_pkg::timer_mode_e mode_i,
	input  logic                dat_we_i,
	input  logic [7:0]          dat_i,
	output logic [7:0]          dat_o,
	output logic                done_o
);
	import mfp_pkg::*;

	logic [7:0] presc;
	logic [7:0] presc_cnt;
	logic [7:0] reload;
	logic       running;
	logic       tick;

	// prescale factor for each delay mode
	always_comb begin
		case (mode_i)
			TM_DIV4:   presc = 8'd4;
			TM_DIV10:  presc = 8'd10;
			TM_DIV16:  presc = 8'd16;
			TM_DIV50:  presc = 8'd50;
			TM_DIV64:  presc = 8'd64;
			TM_DIV100: presc = 8'd100;
			TM_DIV200: presc = 8'd200;
			default:   presc = 8'd1;
		endcase
	end

	assign running = (mode_i != TM_STOP);
	// one tick per prescale period
	assign tick    = running && (presc_cnt == presc - 8'd1);

	always_ff @(posedge iack) begin
		if (reset) begin
			presc_cnt <= '0;
			reload    <= '0;
			dat_o     <= '0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;

			// a control write restarts the prescaler
			if (ctrl_we_i || !running)
				presc_cnt <= '0;
			else
				presc_cnt <= tick ? 8'd0 : presc_cnt + 8'd1;

			// data write while running only changes the reload value
			if (dat_we_i) begin
				reload <= dat_i;
				if (!running)
					dat_o <= dat_i;
			end else if (tick) begin
				if (dat_o == 8'd1) begin
					dat_o  <= reload;
					done_o <= 1'b1;
				end else begin
					// count of 0 wraps to 255, so a reload of 0 gives 256 ticks
					dat_o <= dat_o - 8'd1;
				end
			end
		end
	end

endmodule

// File: source/mfp_top.sv
`timescale 1ns/1ps
`include "mfp_macros.svh"

module mfp_top (
	input  logic       iack,
	input  logic       reset,
	input  logic [7:0] din_i,
	input  logic       sel_i,
	input  logic [4:0] addr_i,
	input  logic       ds_n_i,
	input  logic       rw_i,
	input  logic       int_ack_i,
	input  logic       serial_strobe_out_i,
	input  logic       serial_strobe_in_i,
	input  logic [7:0] serial_data_in_i,
	input  logic [7:0] gpio_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	output logic       serial_data_out_available_o,
	output logic [7:0] serial_data_out_o,
	output logic       serial_data_in_full_o
);
	import mfp_pkg::*;

	logic [7:0]              aer;
	logic [7:0]              vr;
	logic [7:0]              vector;
	logic [`MFP_NUM_IRQ-1:0] ier;
	logic [`MFP_NUM_IRQ-1:0] imr;
	logic [`MFP_NUM_IRQ-1:0] ipr;
	logic [`MFP_NUM_IRQ-1:0] isr;
	logic [`MFP_NUM_IRQ-1:0] ipr_clear;
	logic [`MFP_NUM_IRQ-1:0] isr_clear;
	logic [`MFP_NUM_IRQ-1:0] src;
	logic [3:0]              tmr_ctrl_we;
	logic [3:0]              tmr_dat_we;
	logic [7:0]              tmr_dat;
	logic [3:0][7:0]         tmr_cnt;
	logic [3:0]              tmr_done;
	timer_mode_e             tmr_mode [4];
	logic [7:0]              gpio_lvl;
	logic [7:0]              rx_data;
	logic                    rx_avail;
	logic                    rx_pop;
	logic                    tx_push;
	logic                    tx_full;

	// active edge becomes a rising edge of the level
	assign gpio_lvl = gpio_i ^ ~aer;

	always_comb begin
		src = '0;
		src[IRQ_GPIO0]    = gpio_lvl[0];
		src[IRQ_GPIO1]    = gpio_lvl[1];
		src[IRQ_GPIO2]    = gpio_lvl[2];
		src[IRQ_GPIO3]    = gpio_lvl[3];
		src[IRQ_GPIO4]    = gpio_lvl[4];
		src[IRQ_GPIO5]    = gpio_lvl[5];
		src[IRQ_GPIO6]    = gpio_lvl[6];
		src[IRQ_GPIO7]    = gpio_lvl[7];
		src[IRQ_TIMER_A]  = tmr_done[0];
		src[IRQ_TIMER_B]  = tmr_done[1];
		src[IRQ_TIMER_C]  = tmr_done[2];
		src[IRQ_TIMER_D]  = tmr_done[3];
		// no serial errors are modelled, RX_ERR and TX_ERR stay low
		src[IRQ_RX_FULL]  = rx_avail;
		src[IRQ_TX_EMPTY] = ~tx_full;
	end

	mfp_regs u_regs (
		.iack(iack), .reset(reset),
		.sel_i(sel_i), .ds_n_i(ds_n_i), .rw_i(rw_i),
		.addr_i(mfp_reg_e'(addr_i)), .din_i(din_i), .int_ack_i(int_ack_i),
		.gpio_i(gpio_i), .ipr_i(ipr), .isr_i(isr), .vector_i(vector),
		.tmr_dat_i(tmr_cnt), .rx_data_i(rx_data), .rx_avail_i(rx_avail),
		.tx_full_i(tx_full), .dout_o(dout_o), .aer_o(aer),
		.ier_o(ier), .imr_o(imr), .vr_o(vr),
		.ipr_clear_o(ipr_clear), .isr_clear_o(isr_clear),
		.tmr_ctrl_we_o(tmr_ctrl_we), .tmr_mode_o(tmr_mode),
		.tmr_dat_we_o(tmr_dat_we), .tmr_dat_o(tmr_dat),
		.tx_push_o(tx_push), .rx_pop_o(rx_pop)
	);

	mfp_irq_ctrl u_irq (
		.iack(iack), .reset(reset),
		.src_i(src), .ier_i(ier), .imr_i(imr), .vr_i(vr),
		.ipr_clear_i(ipr_clear), .isr_clear_i(isr_clear),
		.int_ack_i(int_ack_i), .ipr_o(ipr), .isr_o(isr),
		.vector_o(vector), .irq_o(irq_o)
	);

	// timers A to D
	for (genvar t = 0; t < 4; t++) begin : g_timer
		mfp_timer u_timer (
			.iack(iack), .reset(reset),
			.ctrl_we_i(tmr_ctrl_we[t]), .mode_i(tmr_mode[t]),
			.dat_we_i(tmr_dat_we[t]), .dat_i(tmr_dat),
			.dat_o(tmr_cnt[t]), .done_o(tmr_done[t])
		);
	end

	// cpu to io controller
	mfp_byte_fifo #(.DEPTH(`MFP_FIFO_DEPTH)) u_out_fifo (
		.iack(iack), .reset(reset),
		.push_i(tx_push), .data_i(din_i), .pop_i(serial_strobe_out_i),
		.data_o(serial_data_out_o), .full_o(tx_full),
		.avail_o(serial_data_out_available_o)
	);

	// io controller to cpu
	mfp_byte_fifo #(.DEPTH(`MFP_FIFO_DEPTH)) u_in_fifo (
		.iack(iack), .reset(reset),
		.push_i(serial_strobe_in_i), .data_i(serial_data_in_i), .pop_i(rx_pop),
		.data_o(rx_data), .full_o(serial_data_in_full_o), .avail_o(rx_avail)
	);

endmodule

// File: tests/mfp_tb.sv
`timescale 1ns/1ps
`include "mfp_macros.svh"

module mfp_tb;
	import mfp_pkg::*;

	logic                   iack;
	logic                   reset;
	logic [7:0]             din;
	logic                   sel;
	logic [`MFP_ADDR_W-1:0] addr;
	logic                   ds_n;
	logic                   rw;
	logic                   int_ack;
	logic                   strobe_out;
	logic                   strobe_in;
	logic [7:0]             data_in;
	logic [7:0]             gpio;
	logic [7:0]             dout;
	logic                   irq;
	logic                   out_avail;
	logic [7:0]             data_out;
	logic                   in_full;
	int                     cycle_cnt = 0;
	string                  test_name;

	mfp_top DUT (
		.iack(iack), .reset(reset), .din_i(din), .sel_i(sel), .addr_i(addr),
		.ds_n_i(ds_n), .rw_i(rw), .int_ack_i(int_ack),
		.serial_strobe_out_i(strobe_out), .serial_strobe_in_i(strobe_in),
		.serial_data_in_i(data_in), .gpio_i(gpio), .dout_o(dout), .irq_o(irq),
		.serial_data_out_available_o(out_avail), .serial_data_out_o(data_out),
		.serial_data_in_full_o(in_full)
	);

	initial begin
		iack = 1'b0;
		forever #2 iack = ~iack;
	end

	// free running cycle count for timing bounds
	always @(posedge iack)
		cycle_cnt <= cycle_cnt + 1;

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	// one cycle bus access with strobes dropped at the next edge
	task automatic bus_write(input mfp_reg_e r, input logic [7:0] d);
		@(posedge iack);
		sel  <= 1'b1;
		ds_n <= 1'b0;
		rw   <= 1'b0;
		addr <= r;
		din  <= d;
		@(posedge iack);
		sel  <= 1'b0;
		ds_n <= 1'b1;
		rw   <= 1'b1;
	endtask

	// read data is sampled mid cycle before any pop takes effect
	task automatic bus_read(input mfp_reg_e r, output logic [7:0] d);
		@(posedge iack);
		sel  <= 1'b1;
		ds_n <= 1'b0;
		rw   <= 1'b1;
		addr <= r;
		@(negedge iack);
		d = dout;
		@(posedge iack);
		sel  <= 1'b0;
		ds_n <= 1'b1;
	endtask

	// vector latched on the first ack edge and read in the second cycle
	task automatic int_ack_cycle(output logic [7:0] vec);
		@(posedge iack);
		int_ack <= 1'b1;
		@(posedge iack);
		@(negedge iack);
		vec = dout;
		@(posedge iack);
		int_ack <= 1'b0;
	endtask

	task automatic check_reg(input mfp_reg_e r, input logic [7:0] exp);
		logic [7:0] act;
		bus_read(r, act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, r.name(), exp, act);
			abort_run();
		end
	endtask

	task automatic check_vec(input logic [3:0] base, input irq_src_e n, input logic [7:0] act);
		logic [7:0] exp;
		exp = {base, n};
		if (act !== exp) begin
			$display("[ERROR] %s: vector for %s expected %h actual %h",
				test_name, n.name(), exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		@(negedge iack);
		while (irq !== level && n < 64) begin
			@(negedge iack);
			n++;
		end
		if (irq !== level) begin
			$display("%s: irq_o did not reach %b in time", test_name, level);
			abort_run();
		end
	endtask

	task automatic wait_out_avail();
		int n;
		n = 0;
		@(negedge iack);
		while (out_avail !== 1'b1 && n < 64) begin
			@(negedge iack);
			n++;
		end
		if (out_avail !== 1'b1) begin
			$display("%s: out fifo never showed data", test_name);
			abort_run();
		end
	endtask

	task automatic test_reset_state();
		mfp_reg_e   r;
		logic [7:0] exp;
		test_name = "reset_state";
		for (int i = 0; i <= 'h17; i++) begin
			r   = mfp_reg_e'(i);
			exp = (r == GPIP) ? gpio : ((r == TSR) ? 8'h80 : 8'h00);
			check_reg(r, exp);
		end
		@(negedge iack);
		check_flag("irq_o", 1'b0, irq);
		check_flag("serial_data_out_available_o", 1'b0, out_avail);
	endtask

	task automatic test_readback();
		logic [7:0] v [7];
		logic [7:0] gp;
		logic [7:0] gp_exp;
		test_name = "readback";
		foreach (v[i])
			v[i] = $urandom;
		// GPIO0 stays enabled so the disable below has a pending bit to drop
		v[6][0] = 1'b1;
		gp = $urandom;
		bus_write(AER, v[0]);
		bus_write(DDR, v[1]);
		bus_write(GPIP, gp);
		bus_write(IMRA, v[2]);
		bus_write(IMRB, v[3]);
		bus_write(VR, v[4]);
		bus_write(IERA, v[5]);
		bus_write(IERB, v[6]);
		check_reg(AER, v[0]);
		check_reg(DDR, v[1]);
		check_reg(IMRA, v[2]);
		check_reg(IMRB, v[3]);
		check_reg(VR, v[4]);
		check_reg(IERA, v[5]);
		check_reg(IERB, v[6]);
		// each pin reads the written bit where DDR is 1
		for (int i = 0; i < 8; i++)
			gp_exp[i] = v[1][i] ? gp[i] : gpio[i];
		check_reg(GPIP, gp_exp);
		// two AER flips give every pin exactly one active edge
		bus_write(AER, ~v[0]);
		bus_write(AER, v[0]);
		// GPIO sources sit at IPR bits 15:14, 7:6 and 3:0
		check_reg(IPRA, v[5] & 8'hC0);
		check_reg(IPRB, v[6] & 8'hCF);
		// disabling also drops the pending bits
		bus_write(IERA, 8'h00);
		bus_write(IERB, 8'h00);
		bus_write(IMRA, 8'h00);
		bus_write(IMRB, 8'h00);
		bus_write(AER, 8'h00);
		bus_write(DDR, 8'h00);
		bus_write(VR, 8'h00);
		check_reg(IPRA, 8'h00);
		check_reg(IPRB, 8'h00);
	endtask

	task automatic test_uart();
		logic [7:0] q [$];
		logic [7:0] b;
		test_name = "uart";
		// cpu to io controller
		for (int i = 0; i < `MFP_FIFO_DEPTH; i++) begin
			b = $urandom;
			q.push_back(b);
			bus_write(UDR, b);
		end
		check_reg(TSR, 8'h00);
		for (int i = 0; i < `MFP_FIFO_DEPTH; i++) begin
			wait_out_avail();
			check_byte("serial_data_out_o", q.pop_front(), data_out);
			@(posedge iack);
			strobe_out <= 1'b1;
			@(posedge iack);
			strobe_out <= 1'b0;
		end
		@(negedge iack);
		check_flag("serial_data_out_available_o", 1'b0, out_avail);
		check_reg(TSR, 8'h80);
		// io controller to cpu with one extra push while full
		for (int i = 0; i <= `MFP_FIFO_DEPTH; i++) begin
			b = $urandom;
			if (i < `MFP_FIFO_DEPTH)
				q.push_back(b);
			@(posedge iack);
			strobe_in <= 1'b1;
			data_in   <= b;
			@(posedge iack);
			strobe_in <= 1'b0;
		end
		@(negedge iack);
		check_flag("serial_data_in_full_o", 1'b1, in_full);
		check_reg(RSR, 8'h80);
		for (int i = 0; i < `MFP_FIFO_DEPTH; i++)
			check_reg(UDR, q.pop_front());
		check_reg(RSR, 8'h00);
		@(negedge iack);
		check_flag("serial_data_in_full_o", 1'b0, in_full);
	endtask

	task automatic test_gpio_irq();
		logic [3:0] vr_hi;
		logic [7:0] vec;
		test_name = "gpio_irq";
		vr_hi = $urandom;
		@(posedge iack);
		gpio <= 8'h00;
		// rising edges on pins 0 and 7
		bus_write(AER, 8'h81);
		bus_write(IERA, 8'h80);
		bus_write(IERB, 8'h01);
		bus_write(IMRA, 8'h80);
		bus_write(IMRB, 8'h01);
		bus_write(VR, {vr_hi, 4'b1000});
		@(posedge iack);
		gpio <= 8'h81;
		wait_irq(1'b1);
		check_reg(IPRA, 8'h80);
		check_reg(IPRB, 8'h01);
		int_ack_cycle(vec);
		check_vec(vr_hi, IRQ_GPIO7, vec);
		check_reg(ISRA, 8'h80);
		check_reg(IPRA, 8'h00);
		// GPIO0 still pending but below the level in service
		@(negedge iack);
		check_flag("irq_o under ISR bit 15", 1'b0, irq);
		bus_write(ISRA, 8'h00);
		wait_irq(1'b1);
		int_ack_cycle(vec);
		check_vec(vr_hi, IRQ_GPIO0, vec);
		check_reg(ISRB, 8'h01);
		bus_write(ISRB, 8'h00);
		// automatic end of interrupt
		bus_write(VR, {vr_hi, 4'b0000});
		@(posedge iack);
		gpio <= 8'h01;
		repeat (3) @(posedge iack);
		gpio <= 8'h81;
		wait_irq(1'b1);
		int_ack_cycle(vec);
		check_vec(vr_hi, IRQ_GPIO7, vec);
		check_reg(ISRA, 8'h00);
		check_reg(ISRB, 8'h00);
		check_reg(IPRA, 8'h00);
		wait_irq(1'b0);
		bus_write(IERA, 8'h00);
		bus_write(IERB, 8'h00);
		bus_write(IMRA, 8'h00);
		bus_write(IMRB, 8'h00);
	endtask

	task automatic test_timers();
		logic [7:0] v;
		logic [7:0] rd;
		logic [7:0] first_cnt;
		logic [7:0] second_cnt;
		int         start;
		int         limit;
		test_name = "timers";
		v = 8'd3 + ($urandom % 6);
		bus_write(IERB, 8'h10);
		bus_write(IMRB, 8'h10);
		// stopped timer takes the data write as its count
		bus_write(TDDR, v);
		check_reg(TDDR, v);
		start = cycle_cnt;
		bus_write(TCDCR, {5'b00000, TM_DIV4});
		limit = v * 4 + 24;
		rd = 8'h00;
		while (!rd[4]) begin
			bus_read(IPRB, rd);
			if (!rd[4] && (cycle_cnt - start > limit)) begin
				$display("%s: timer D interrupt not pending within %0d cycles", test_name, limit);
				abort_run();
			end
		end
		bus_write(IPRB, 8'h00);
		check_reg(IPRB, 8'h00);
		// long count so no reload falls between the samples
		bus_write(TCDCR, {5'b00000, TM_STOP});
		bus_write(TDDR, 8'd100);
		bus_write(TCDCR, {5'b00000, TM_DIV4});
		bus_read(TDDR, first_cnt);
		repeat (12) @(posedge iack);
		bus_read(TDDR, second_cnt);
		check_flag("TDDR count decreases", 1'b1, second_cnt < first_cnt);
		bus_write(TCDCR, {5'b00000, TM_STOP});
		v = $urandom;
		bus_write(TDDR, v);
		check_reg(TDDR, v);
		repeat (40) @(posedge iack);
		check_reg(TDDR, v);
		bus_write(IERB, 8'h00);
		bus_write(IMRB, 8'h00);
	endtask

	// bound on the whole run
	initial begin
		#200000;
		$display("simulation ran past its time limit");
		abort_run();
	end

	initial begin
		void'($urandom(32'hff86));
		reset      <= 1'b1;
		din        <= 8'h00;
		sel        <= 1'b0;
		addr       <= '0;
		ds_n       <= 1'b1;
		rw         <= 1'b1;
		int_ack    <= 1'b0;
		strobe_out <= 1'b0;
		strobe_in  <= 1'b0;
		data_in    <= 8'h00;
		gpio       <= $urandom;
		repeat (16) @(posedge iack);
		reset <= 1'b0;
		@(posedge iack);
		test_reset_state();
		test_readback();
		test_uart();
		test_gpio_irq();
		test_timers();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
source/mfp_pkg.sv
source/mfp_byte_fifo.sv
source/mfp_timer.sv
source/mfp_regs.sv
source/mfp_irq_ctrl.sv
source/mfp_top.sv
tests/mfp_tb.sv
